// File: hw/taint_pkg.sv
`default_nettype none

package taint_pkg;

    typedef logic [7:0] data_t;
    typedef logic [7:0] taint_t;
    typedef logic [3:0] addr_t;
    // 0 to 16 tainted words
    typedef logic [4:0] count_t;

    typedef enum logic [2:0] {
        op_and = 3'd0,
        op_or  = 3'd1,
        op_eq  = 3'd2,
        op_shl = 3'd3,
        op_shr = 3'd4,
        op_mul = 3'd5,
        op_add = 3'd6
    } op_t;

    // shadow taint of one two-operand result
    function automatic taint_t op_taint(input op_t op, input data_t a, input taint_t a_taint,
                                        input data_t b, input taint_t b_taint);
        taint_t care;
        logic   any_taint;
        care = ~(a_taint | b_taint);
        any_taint = |{a_taint, b_taint};
        case (op)
            op_and: op_taint = (a_taint & b) | (b_taint & a) | (a_taint & b_taint);
            op_or: op_taint = (a_taint & ~b) | (b_taint & ~a) | (a_taint & b_taint);
            // only untainted bits decide, result lives in bit 0
            op_eq: op_taint = taint_t'(((a & care) == (b & care)) && any_taint);
            op_shl: op_taint = (|b_taint) ? '1 : a_taint << b[2:0];
            op_shr: op_taint = (|b_taint) ? '1 : a_taint >> b[2:0];
            op_mul: op_taint = {8{any_taint}};
            default: op_taint = a_taint | b_taint;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hw/taint_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// one result word on its way to the memory
interface taint_stage_if;

    logic                 valid;
    taint_pkg::data_t     data;
    taint_pkg::taint_t    taint;
    taint_pkg::addr_t     addr;
    logic                 addr_taint;

    modport src (
        output valid, data, taint, addr, addr_taint
    );

    modport dst (
        input valid, data, taint, addr, addr_taint
    );

endinterface

`default_nettype wire

// File: hw/taint_op_stage.sv
`timescale 1ns/1ps
`default_nettype none

module taint_op_stage (
    input  logic                pos_clk,
    input  logic                pos_arst,
    input  logic                in_valid,
    input  taint_pkg::op_t      op,
    input  taint_pkg::data_t    a,
    input  taint_pkg::taint_t   a_taint,
    input  taint_pkg::data_t    b,
    input  taint_pkg::taint_t   b_taint,
    input  taint_pkg::addr_t    wr_addr,
    input  logic                wr_addr_taint,
    taint_stage_if.src          out
);

    logic [2:0]          shamt;
    logic [15:0]         product;
    logic                is_equal;
    taint_pkg::data_t    res_next;
    taint_pkg::taint_t   taint_next;

    // only the low 3 bits of b shift an 8-bit word
    assign shamt = b[2:0];
    assign product = 16'(a) * 16'(b);
    assign is_equal = (a == b);

    always_comb begin
        case (op)
            taint_pkg::op_and: begin
                res_next = a & b;
            end
            taint_pkg::op_or: begin
                res_next = a | b;
            end
            taint_pkg::op_eq: begin
                res_next = taint_pkg::data_t'(is_equal);
            end
            taint_pkg::op_shl: begin
                res_next = a << shamt;
            end
            taint_pkg::op_shr: begin
                res_next = a >> shamt;
            end
            taint_pkg::op_mul: begin
                // keep the low byte only
                res_next = product[7:0];
            end
            taint_pkg::op_add: begin
                res_next = a + b;
            end
            default: begin
                res_next = '0;
            end
        endcase
    end

    assign taint_next = taint_pkg::op_taint(op, a, a_taint, b, b_taint);

    // control and taint flags
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            out.valid      <= 1'b0;
            out.taint      <= '0;
            out.addr_taint <= 1'b0;
        end else begin
            out.valid <= in_valid;
            if (in_valid) begin
                out.taint      <= taint_next;
                out.addr_taint <= wr_addr_taint;
            end
        end
    end

    // payload
    always_ff @(posedge pos_clk) begin
        if (in_valid) begin
            out.data <= res_next;
            out.addr <= wr_addr;
        end
    end

endmodule

`default_nettype wire

// File: hw/taint_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module taint_mem_stage #(
    parameter int addr_bits = 4
) (
    input  logic                 pos_clk,
    input  logic                 pos_arst,
    taint_stage_if.dst           in,
    input  logic                 rd_en,
    input  taint_pkg::addr_t     rd_addr,
    input  logic                 rd_addr_taint,
    output logic                 rd_valid,
    output taint_pkg::data_t     rd_data,
    output taint_pkg::taint_t    rd_taint,
    output taint_pkg::count_t    tainted_words
);

    localparam int depth = 2 ** addr_bits;

    taint_pkg::data_t    data_mem [depth];
    taint_pkg::taint_t   taint_mem [depth];

    taint_pkg::taint_t   wr_taint;
    logic                was_tainted;
    logic                now_tainted;
    logic                count_up;
    logic                count_down;

    // a tainted write address taints the whole word
    assign wr_taint = in.addr_taint ? '1 : in.taint;

    assign was_tainted = |taint_mem[in.addr];
    assign now_tainted = |wr_taint;
    assign count_up    = in.valid && !was_tainted && now_tainted;
    assign count_down  = in.valid && was_tainted && !now_tainted;

    always_ff @(posedge pos_clk) begin
        if (in.valid) begin
            data_mem[in.addr] <= in.data;
        end
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            for (int i = 0; i < depth; i++) begin
                taint_mem[i] <= '0;
            end
        end else if (in.valid) begin
            taint_mem[in.addr] <= wr_taint;
        end
    end

    // tracks the number of words with any taint bit set
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            tainted_words <= '0;
        end else if (count_up) begin
            tainted_words <= tainted_words + 1'b1;
        end else if (count_down) begin
            tainted_words <= tainted_words - 1'b1;
        end
    end

    // synchronous read, old contents on a same-cycle write
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            rd_valid <= 1'b0;
            rd_taint <= '0;
        end else begin
            rd_valid <= rd_en;
            if (rd_en) begin
                rd_taint <= rd_addr_taint ? '1 : taint_mem[rd_addr];
            end
        end
    end

    always_ff @(posedge pos_clk) begin
        if (rd_en) begin
            rd_data <= data_mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: hw/taint_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module taint_pipe #(
    parameter int addr_bits = 4
) (
    input  logic                 pos_clk,
    input  logic                 pos_arst,

    input  logic                 in_valid,
    input  taint_pkg::op_t       op,
    input  taint_pkg::data_t     a,
    input  taint_pkg::taint_t    a_taint,
    input  taint_pkg::data_t     b,
    input  taint_pkg::taint_t    b_taint,
    input  taint_pkg::addr_t     wr_addr,
    input  logic                 wr_addr_taint,

    input  logic                 rd_en,
    input  taint_pkg::addr_t     rd_addr,
    input  logic                 rd_addr_taint,

    output logic                 res_valid,
    output taint_pkg::data_t     res,
    output taint_pkg::taint_t    res_taint,

    output logic                 rd_valid,
    output taint_pkg::data_t     rd_data,
    output taint_pkg::taint_t    rd_taint,
    output taint_pkg::count_t    tainted_words
);

    taint_stage_if u_stage_if ();

    taint_op_stage u_op_stage (
        .pos_clk       (pos_clk),
        .pos_arst      (pos_arst),
        .in_valid      (in_valid),
        .op            (op),
        .a             (a),
        .a_taint       (a_taint),
        .b             (b),
        .b_taint       (b_taint),
        .wr_addr       (wr_addr),
        .wr_addr_taint (wr_addr_taint),
        .out           (u_stage_if.src)
    );

    taint_mem_stage #(
        .addr_bits (addr_bits)
    ) u_mem_stage (
        .pos_clk       (pos_clk),
        .pos_arst      (pos_arst),
        .in            (u_stage_if.dst),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_addr_taint (rd_addr_taint),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .rd_taint      (rd_taint),
        .tainted_words (tainted_words)
    );

    // operation result is visible as it enters the memory stage
    assign res_valid = u_stage_if.valid;
    assign res       = u_stage_if.data;
    assign res_taint = u_stage_if.taint;

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic pos_clk,
    output logic pos_arst
);

    initial begin
        pos_clk = 1'b0;
        forever #50 pos_clk = ~pos_clk;
    end

    // reset held for 5 rising edges, released on a falling edge
    initial begin
        pos_arst = 1'b0;
        #1;
        pos_arst = 1'b1;
        repeat (5) @(posedge pos_clk);
        @(negedge pos_clk);
        pos_arst = 1'b0;
    end

endmodule

`default_nettype wire

// File: test/taint_pipe_props.sv
`timescale 1ns/1ps
`default_nettype none

module taint_pipe_props (
    input logic                pos_clk,
    input logic                pos_arst,
    input logic                in_valid,
    input taint_pkg::op_t      op,
    input taint_pkg::data_t    a,
    input taint_pkg::taint_t   a_taint,
    input taint_pkg::data_t    b,
    input taint_pkg::taint_t   b_taint,
    input taint_pkg::addr_t    wr_addr,
    input logic                wr_addr_taint,
    input logic                rd_en,
    input taint_pkg::addr_t    rd_addr,
    input logic                rd_addr_taint,
    input logic                res_valid,
    input taint_pkg::data_t    res,
    input taint_pkg::taint_t   res_taint,
    input logic                rd_valid,
    input taint_pkg::data_t    rd_data,
    input taint_pkg::taint_t   rd_taint,
    input taint_pkg::count_t   tainted_words
);

    int value_errors = 0;
    int reset_errors = 0;

    logic [7:0] shadow_data [16];
    logic [7:0] shadow_taint [16];
    logic [15:0] shadow_written;
    int shadow_count;

    logic       chk_res;
    logic [7:0] exp_res;
    logic [7:0] exp_res_taint;
    logic [3:0] exp_addr;
    logic       exp_addr_taint;
    logic       chk_rd;
    logic       chk_rd_data;
    logic [7:0] exp_rd_data;
    logic [7:0] exp_rd_taint;

    function automatic logic [7:0] calc_result(input logic [2:0] o, input logic [7:0] x,
                                               input logic [7:0] y);
        logic [15:0] prod;
        prod = x * y;
        case (o)
            3'd0: calc_result = x & y;
            3'd1: calc_result = x | y;
            3'd2: calc_result = {7'd0, x == y};
            3'd3: calc_result = x << y[2:0];
            3'd4: calc_result = x >> y[2:0];
            3'd5: calc_result = prod[7:0];
            default: calc_result = x + y;
        endcase
    endfunction

    function automatic logic [7:0] calc_taint(input logic [2:0] o, input logic [7:0] x,
                                              input logic [7:0] xt, input logic [7:0] y,
                                              input logic [7:0] yt);
        logic [7:0] both;
        both = xt | yt;
        case (o)
            3'd0: calc_taint = (xt & y) | (yt & x) | (xt & yt);
            3'd1: calc_taint = (xt & ~y) | (yt & ~x) | (xt & yt);
            // clean bits of a and b must agree
            3'd2: calc_taint = {7'd0, (both != 0) && (((x ^ y) & ~both) == 0)};
            3'd3: calc_taint = (yt != 0) ? 8'hff : xt << y[2:0];
            3'd4: calc_taint = (yt != 0) ? 8'hff : xt >> y[2:0];
            3'd5: calc_taint = (both != 0) ? 8'hff : 8'h00;
            default: calc_taint = both;
        endcase
    endfunction

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            chk_res <= 1'b0;
            chk_rd <= 1'b0;
            shadow_written <= '0;
            for (int i = 0; i < 16; i++) begin
                shadow_taint[i] <= '0;
            end
        end else begin
            chk_res <= in_valid;
            chk_rd <= rd_en;
            if (in_valid) begin
                exp_res <= calc_result(op, a, b);
                exp_res_taint <= calc_taint(op, a, a_taint, b, b_taint);
                exp_addr <= wr_addr;
                exp_addr_taint <= wr_addr_taint;
            end
            if (chk_res) begin
                shadow_data[exp_addr] <= exp_res;
                shadow_taint[exp_addr] <= exp_addr_taint ? 8'hff : exp_res_taint;
                shadow_written[exp_addr] <= 1'b1;
            end
            if (rd_en) begin
                chk_rd_data <= shadow_written[rd_addr];
                exp_rd_data <= shadow_data[rd_addr];
                exp_rd_taint <= rd_addr_taint ? 8'hff : shadow_taint[rd_addr];
            end
        end
    end

    always_comb begin
        shadow_count = 0;
        for (int i = 0; i < 16; i++) begin
            if (shadow_taint[i] != 0) shadow_count++;
        end
    end

    a_res_valid: assert property (@(posedge pos_clk) disable iff (pos_arst)
        res_valid == chk_res)
    else begin
        value_errors++;
        $error("mismatch at %0t: res_valid expected %b actual %b", $time,
               chk_res, res_valid);
    end

    a_res_taint: assert property (@(posedge pos_clk) disable iff (pos_arst)
        chk_res |-> res_taint == exp_res_taint)
    else begin
        value_errors++;
        $error("mismatch at %0t: res_taint expected %h actual %h", $time,
               exp_res_taint, res_taint);
    end

    a_res_value: assert property (@(posedge pos_clk) disable iff (pos_arst)
        chk_res |-> res == exp_res)
    else begin
        value_errors++;
        $error("mismatch at %0t: res expected %h actual %h", $time, exp_res, res);
    end

    a_rd_valid: assert property (@(posedge pos_clk) disable iff (pos_arst)
        rd_valid == chk_rd)
    else begin
        value_errors++;
        $error("mismatch at %0t: rd_valid expected %b actual %b", $time,
               chk_rd, rd_valid);
    end

    a_rd_taint: assert property (@(posedge pos_clk) disable iff (pos_arst)
        chk_rd |-> rd_taint == exp_rd_taint)
    else begin
        value_errors++;
        $error("mismatch at %0t: rd_taint expected %h actual %h", $time,
               exp_rd_taint, rd_taint);
    end

    a_rd_data: assert property (@(posedge pos_clk) disable iff (pos_arst)
        chk_rd && chk_rd_data |-> rd_data == exp_rd_data)
    else begin
        value_errors++;
        $error("mismatch at %0t: rd_data expected %h actual %h", $time,
               exp_rd_data, rd_data);
    end

    a_count: assert property (@(posedge pos_clk) disable iff (pos_arst)
        tainted_words == shadow_count && tainted_words <= 16)
    else begin
        value_errors++;
        $error("mismatch at %0t: tainted_words expected %0d actual %0d", $time,
               shadow_count, tainted_words);
    end

    a_reset: assert property (@(posedge pos_clk)
        pos_arst || $fell(pos_arst) |-> !res_valid && !rd_valid && tainted_words == 0)
    else begin
        reset_errors++;
        $error("outputs not cleared during or just after reset at %0t", $time);
    end

endmodule

bind taint_pipe taint_pipe_props u_props (.*);

`default_nettype wire

// File: test/tb_taint_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_taint_pipe;

    logic pos_clk;
    logic pos_arst;
    logic in_valid;
    taint_pkg::op_t op;
    taint_pkg::data_t a;
    taint_pkg::taint_t a_taint;
    taint_pkg::data_t b;
    taint_pkg::taint_t b_taint;
    taint_pkg::addr_t wr_addr;
    logic wr_addr_taint;
    logic rd_en;
    taint_pkg::addr_t rd_addr;
    logic rd_addr_taint;
    logic res_valid;
    taint_pkg::data_t res;
    taint_pkg::taint_t res_taint;
    logic rd_valid;
    taint_pkg::data_t rd_data;
    taint_pkg::taint_t rd_taint;
    taint_pkg::count_t tainted_words;

    logic [31:0] seed = 32'd40;
    int cycles = 0;
    int total;

    tb_clock u_clock (.pos_clk(pos_clk), .pos_arst(pos_arst));

    taint_pipe #(.addr_bits(4)) u_taint_pipe (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] rand_byte();
        seed = lcg_next(seed);
        rand_byte = seed[23:16];
    endfunction

    // one falling-edge step with a write and a read
    task automatic apply(input logic v, input logic [2:0] o, input logic [7:0] x,
                         input logic [7:0] xt, input logic [7:0] y, input logic [7:0] yt,
                         input logic [3:0] wa, input logic wat, input logic re,
                         input logic [3:0] ra, input logic rat);
        in_valid = v;
        op = taint_pkg::op_t'(o);
        a = x;
        a_taint = xt;
        b = y;
        b_taint = yt;
        wr_addr = wa;
        wr_addr_taint = wat;
        rd_en = re;
        rd_addr = ra;
        rd_addr_taint = rat;
        @(negedge pos_clk);
    endtask

    always @(posedge pos_clk) begin
        cycles++;
        if (cycles >= 400) begin
            $display("timeout: stimulus did not complete within 400 cycles");
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        logic [7:0] r;
        apply(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        @(negedge pos_arst);
        @(negedge pos_clk);
        for (int i = 0; i < 120; i++) begin
            r = rand_byte();
            apply(r[0], 3'(rand_byte() % 7), rand_byte(),
                  r[1] ? rand_byte() & rand_byte() : 8'h00, rand_byte(),
                  r[2] ? rand_byte() & rand_byte() : 8'h00,
                  4'(rand_byte()), r[3] & r[4], r[5], 4'(rand_byte()), r[6] & r[7]);
        end
        // clean fill
        for (int i = 0; i < 16; i++) begin
            apply(1, 3'd6, rand_byte(), 0, rand_byte(), 0, 4'(i), 0, 0, 0, 0);
        end
        apply(0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0);
        for (int i = 0; i < 16; i++) begin
            apply(1, 3'(i % 7), rand_byte(), rand_byte(), rand_byte(),
                  (i % 2) ? rand_byte() : 8'h00, 4'(i), (i % 3) == 0, 0, 0, 0);
        end
        // eq with equal and unequal clean bits
        apply(1, 3'd2, 8'h5a, 8'h00, 8'h5a, 8'h00, 4'd0, 0, 0, 0, 0);
        apply(1, 3'd2, 8'h5a, 8'h0f, 8'h53, 8'h00, 4'd1, 0, 0, 0, 0);
        apply(1, 3'd2, 8'h5a, 8'h01, 8'h5a, 8'h00, 4'd2, 0, 0, 0, 0);
        apply(1, 3'd2, 8'h5a, 8'h01, 8'h3a, 8'h00, 4'd3, 0, 0, 0, 0);
        apply(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        for (int i = 0; i < 24; i++) begin
            apply(0, 0, 0, 0, 0, 0, 0, 0, 1, 4'(i), i >= 16);
        end
        repeat (4) apply(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        total = u_taint_pipe.u_props.value_errors + u_taint_pipe.u_props.reset_errors;
        $display("errors: value %0d, reset %0d", u_taint_pipe.u_props.value_errors,
                 u_taint_pipe.u_props.reset_errors);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
hw/taint_pkg.sv
hw/taint_stage_if.sv
hw/taint_op_stage.sv
hw/taint_mem_stage.sv
hw/taint_pipe.sv
test/tb_clock.sv
test/taint_pipe_props.sv
test/tb_taint_pipe.sv
